//--- filelist.f
rtl/cachePkg.sv
rtl/memBusPkg.sv
rtl/cacheCtrl.sv
rtl/tagStore.sv
rtl/dataStore.sv
rtl/refillUnit.sv
rtl/dCacheTop.sv
dv/dCacheProps.sv
dv/dCacheTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module dCacheTb -f filelist.f -o dCacheSim

./obj_dir/dCacheSim

//--- dv/dCacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module dCacheTb;

  localparam int ExpectAny = 0;
  localparam int ExpectHit = 1;
  localparam int ExpectMiss = 2;
  localparam int CyclesPerTest = 200;

  typedef struct {
    cachePkg::cacheOp_e  op;
    logic [31:0]         addr;
    cachePkg::word_t     data;
    cachePkg::byteMask_t mask;
    int                  outcome;
    string               name;
  } stim_t;

  logic                clk;
  logic                rst_n;
  logic                reqValid_i;
  cachePkg::cacheReq_t req_i;
  logic                reqReady_o;
  logic                respValid_o;
  cachePkg::word_t     respData_o;
  logic                rdValid_o;
  memBusPkg::rdReq_t   rdReq_o;
  logic                rdReady_i;
  logic                beatValid_i;
  memBusPkg::rdBeat_t  beat_i;
  logic                wrValid_o;
  memBusPkg::wrReq_t   wrReq_o;
  logic                wrReady_i;

  stim_t               stimTable[$];
  // memory as the bus sees it, and as the program should see it
  memBusPkg::line_t    mem [logic [31:0]];
  memBusPkg::line_t    refMem [logic [31:0]];
  logic [15:0]         lfsrState = 16'd55;
  int                  readCount = 0;
  int                  wrCount = 0;
  string               curName = "reset";
  logic [31:0]         curLine = '0;

  dCacheTop #(.VictimSeed(16'h5a3c)) u_dut (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid_i), .req_i(req_i),
    .reqReady_o(reqReady_o), .respValid_o(respValid_o), .respData_o(respData_o),
    .rdValid_o(rdValid_o), .rdReq_o(rdReq_o),
    .rdReady_i(rdReady_i), .beatValid_i(beatValid_i), .beat_i(beat_i),
    .wrValid_o(wrValid_o), .wrReq_o(wrReq_o), .wrReady_i(wrReady_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // x^16 + x^15 + x^13 + x^4 + 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[14] ^ lfsrState[12] ^ lfsrState[3];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
  endfunction

  function automatic int randBits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsrBit());
    end
    return v;
  endfunction

  // random bits folded with the line address
  function automatic memBusPkg::line_t makeLine(input logic [31:0] lineAddr);
    memBusPkg::line_t l;
    for (int i = 0; i < memBusPkg::LineWidth; i++) begin
      l[i] = lfsrBit();
    end
    return l ^ {8{lineAddr}};
  endfunction

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      failNow($sformatf("** Error [%s] expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic checkWord(input string name, input cachePkg::word_t exp,
                           input cachePkg::word_t act);
    if (act !== exp) begin
      failNow($sformatf("** Error [%s] expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic checkLine(input string name, input memBusPkg::line_t exp,
                           input memBusPkg::line_t act);
    if (act !== exp) begin
      failNow($sformatf("** Error [%s] expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic checkRdReq(input string name, input memBusPkg::rdReq_t exp,
                            input memBusPkg::rdReq_t act);
    if (act !== exp) begin
      failNow($sformatf("** Error [%s] expected %h actual %h", name, exp.lineAddr,
                        act.lineAddr));
    end
  endtask

  task automatic addStim(input cachePkg::cacheOp_e op, input logic [31:0] addr,
                         input cachePkg::word_t data, input cachePkg::byteMask_t mask,
                         input int outcome, input string name);
    stim_t s;
    s.op = op;
    s.addr = addr;
    s.data = data;
    s.mask = mask;
    s.outcome = outcome;
    s.name = name;
    stimTable.push_back(s);
  endtask

  task automatic buildTable();
    addStim(cachePkg::opLoad, 32'h0000_0838, '0, '0, ExpectMiss, "load miss");
    addStim(cachePkg::opLoad, 32'h0000_0820, '0, '0, ExpectHit, "load hit dw0");
    addStim(cachePkg::opLoad, 32'h0000_0830, '0, '0, ExpectHit, "load hit dw2");
    addStim(cachePkg::opStore, 32'h0000_0828, 64'h1122_3344_5566_7788, 8'b0011_0101,
            ExpectHit, "partial store");
    addStim(cachePkg::opLoad, 32'h0000_0828, '0, '0, ExpectHit, "load after store");
    addStim(cachePkg::opStore, 32'h0000_1060, 64'hdead_beef_0bad_f00d, 8'hf0,
            ExpectMiss, "store miss");
    addStim(cachePkg::opLoad, 32'h0000_1060, '0, '0, ExpectHit, "load after store miss");
    // three tags on index 5, two of them dirty
    addStim(cachePkg::opStore, 32'h0000_20a8, 64'ha5a5_0101_5a5a_0202, 8'hff,
            ExpectMiss, "conflict store A");
    addStim(cachePkg::opStore, 32'h0000_30b0, 64'h0f0f_1234_f0f0_5678, 8'h0f,
            ExpectMiss, "conflict store B");
    addStim(cachePkg::opLoad, 32'h0000_40b8, '0, '0, ExpectMiss, "conflict load C");
    addStim(cachePkg::opLoad, 32'h0000_20a8, '0, '0, ExpectAny, "reload A");
    addStim(cachePkg::opLoad, 32'h0000_30b0, '0, '0, ExpectAny, "reload B");
    addStim(cachePkg::opLoad, 32'h0000_40a0, '0, '0, ExpectAny, "reload C");
    addStim(cachePkg::opStore, 32'h0000_0838, 64'h7700_0000_0000_0000, 8'h80,
            ExpectHit, "store top byte");
    addStim(cachePkg::opLoad, 32'h0000_0838, '0, '0, ExpectHit, "load top byte");
  endtask

  task automatic preloadMemory();
    logic [31:0] la;
    foreach (stimTable[i]) begin
      la = {stimTable[i].addr[31:5], 5'b0};
      if (!mem.exists(la)) begin
        mem[la] = makeLine(la);
        refMem[la] = mem[la];
      end
    end
  endtask

  task automatic runRequest(input stim_t s);
    int               cycles;
    int               readsBefore;
    logic [31:0]      lineAddr;
    memBusPkg::line_t line;
    lineAddr = {s.addr[31:5], 5'b0};
    curName = s.name;
    curLine = lineAddr;
    readsBefore = readCount;
    @(posedge clk);
    #1;
    reqValid_i = 1'b1;
    req_i.op = s.op;
    req_i.addr = s.addr;
    req_i.data = s.data;
    req_i.mask = s.mask;
    @(negedge clk);
    while (!reqReady_o) @(negedge clk);
    @(posedge clk);
    #1;
    reqValid_i = 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!respValid_o);
    line = refMem[lineAddr];
    if (s.op == cachePkg::opLoad) begin
      checkWord(s.name, line[s.addr[4:3]*64 +: 64], respData_o);
    end else begin
      for (int b = 0; b < 8; b++) begin
        if (s.mask[b]) begin
          line[s.addr[4:3]*64 + b*8 +: 8] = s.data[b*8 +: 8];
        end
      end
      refMem[lineAddr] = line;
    end
    if (s.outcome == ExpectHit) begin
      if (cycles != 1) begin
        failNow($sformatf("[%s] hit took %0d cycles instead of one", s.name, cycles));
      end
      // a read started by the compare would be visible one cycle later
      @(negedge clk);
      checkFlag({s.name, " no read"}, 1'b0, rdValid_o);
    end
    if (s.outcome == ExpectMiss && readCount != readsBefore + 1) begin
      failNow($sformatf("[%s] miss did not read its line from memory", s.name));
    end
  endtask

  // read port with random ready delay and beat gaps
  initial begin : readPort
    memBusPkg::rdReq_t expReq;
    memBusPkg::line_t  line;
    int                delay;
    rdReady_i = 1'b0;
    beatValid_i = 1'b0;
    beat_i = '0;
    forever begin
      @(posedge clk);
      #1;
      if (rdValid_o) begin
        delay = randBits(2);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        expReq.lineAddr = curLine;
        checkRdReq(curName, expReq, rdReq_o);
        line = mem[rdReq_o.lineAddr];
        readCount++;
        rdReady_i = 1'b1;
        @(posedge clk);
        #1;
        rdReady_i = 1'b0;
        for (int b = 0; b < memBusPkg::BeatsPerLine; b++) begin
          if (lfsrBit()) begin
            beatValid_i = 1'b0;
            @(posedge clk);
            #1;
          end
          beatValid_i = 1'b1;
          beat_i.data = line[b*64 +: 64];
          beat_i.last = (b == memBusPkg::BeatsPerLine - 1);
          @(posedge clk);
          #1;
        end
        beatValid_i = 1'b0;
      end
    end
  end

  initial begin : writePort
    int delay;
    wrReady_i = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (wrValid_o) begin
        delay = randBits(2);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        if (!refMem.exists(wrReq_o.lineAddr)) begin
          failNow("write-back to a line that was never loaded");
        end
        checkLine(curName, refMem[wrReq_o.lineAddr], wrReq_o.data);
        mem[wrReq_o.lineAddr] = wrReq_o.data;
        wrCount++;
        wrReady_i = 1'b1;
        @(posedge clk);
        #1;
        wrReady_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    int limit;
    #1;
    limit = stimTable.size() * CyclesPerTest + 16;
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, the cache stopped responding", limit);
    $display("Test failures found");
    $fatal(1, "timeout");
  end

  initial begin
    rst_n = 1'b0;
    reqValid_i = 1'b0;
    req_i = '0;
    buildTable();
    preloadMemory();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    checkFlag("reset reqReady", 1'b1, reqReady_o);
    checkFlag("reset respValid", 1'b0, respValid_o);
    checkFlag("reset rdValid", 1'b0, rdValid_o);
    checkFlag("reset wrValid", 1'b0, wrValid_o);
    foreach (stimTable[i]) begin
      runRequest(stimTable[i]);
    end
    if (wrCount < 1) begin
      failNow("the conflicting lines caused no write-back");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- dv/dCacheProps.sv
`timescale 1ns/1ps
`default_nettype none

module dCacheProps (
  input wire                    clk,
  input wire                    rst_n,
  input wire                    reqValid_i,
  input wire                    reqReady_i,
  input wire                    respValid_i,
  input wire                    rdValid_i,
  input wire                    rdReady_i,
  input wire memBusPkg::rdReq_t rdReq_i,
  input wire                    wrValid_i,
  input wire                    wrReady_i,
  input wire memBusPkg::wrReq_t wrReq_i
);

  // set on acceptance, cleared by the response
  logic pending;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (reqValid_i && reqReady_i) begin
      pending <= 1'b1;
    end else if (respValid_i) begin
      pending <= 1'b0;
    end
  end

  rdHold: assert property (@(posedge clk) disable iff (!rst_n)
    rdValid_i && !rdReady_i |=> rdValid_i && $stable(rdReq_i))
    else $error("read request dropped or changed before acceptance");

  wrHold: assert property (@(posedge clk) disable iff (!rst_n)
    wrValid_i && !wrReady_i |=> wrValid_i && $stable(wrReq_i))
    else $error("write-back request dropped or changed before acceptance");

  readyVsResp: assert property (@(posedge clk) disable iff (!rst_n)
    !(reqReady_i && respValid_i))
    else $error("ready and response high together");

  oneResp: assert property (@(posedge clk) disable iff (!rst_n)
    respValid_i |-> pending)
    else $error("response without an accepted request");

  resetState: assert property (@(posedge clk)
    !rst_n |-> reqReady_i && !respValid_i && !rdValid_i && !wrValid_i)
    else $error("outputs wrong while in reset");

endmodule

bind dCacheTop dCacheProps u_props (
  .clk(clk), .rst_n(rst_n),
  .reqValid_i(reqValid_i), .reqReady_i(reqReady_o), .respValid_i(respValid_o),
  .rdValid_i(rdValid_o), .rdReady_i(rdReady_i), .rdReq_i(rdReq_o),
  .wrValid_i(wrValid_o), .wrReady_i(wrReady_i), .wrReq_i(wrReq_o)
);

`default_nettype wire

//--- rtl/dCacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module dCacheTop #(
  parameter logic [15:0] VictimSeed = 16'hace1
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        reqValid_i,
  input  wire cachePkg::cacheReq_t   req_i,
  output logic                       reqReady_o,
  output logic                       respValid_o,
  output cachePkg::word_t            respData_o,
  output logic                       rdValid_o,
  output memBusPkg::rdReq_t          rdReq_o,
  input  wire                        rdReady_i,
  input  wire                        beatValid_i,
  input  wire memBusPkg::rdBeat_t    beat_i,
  output logic                       wrValid_o,
  output memBusPkg::wrReq_t          wrReq_o,
  input  wire                        wrReady_i
);

  cachePkg::addrFields_t         reqAddr;
  cachePkg::word_t               storeData;
  cachePkg::byteMask_t           storeMask;
  logic                          hit;
  logic                          hitWay;
  logic                          victimWay;
  logic                          victimDirty;
  logic [cachePkg::TagWidth-1:0] victimTag;
  logic                          storeWr;
  logic                          lineFill;
  logic                          tagUpdate;
  logic                          startRead;
  logic                          startWrBack;
  logic                          rdAccepted;
  logic                          wrAccepted;
  logic                          fillDone;
  memBusPkg::line_t              lineBuffer;
  memBusPkg::line_t              victimLine;

  cacheCtrl u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid_i), .req_i(req_i),
    .reqReady_o(reqReady_o), .respValid_o(respValid_o),
    .reqAddr_o(reqAddr), .storeData_o(storeData), .storeMask_o(storeMask),
    .hit_i(hit), .victimDirty_i(victimDirty),
    .storeWr_o(storeWr), .lineFill_o(lineFill), .tagUpdate_o(tagUpdate),
    .startRead_o(startRead), .startWrBack_o(startWrBack),
    .rdAccepted_i(rdAccepted), .wrAccepted_i(wrAccepted), .fillDone_i(fillDone)
  );

  // a response marks a finished lookup, which steps the victim lfsr
  tagStore #(.VictimSeed(VictimSeed)) u_tags (
    .clk(clk), .rst_n(rst_n),
    .reqAddr_i(reqAddr),
    .checkEn_i(respValid_o), .storeWr_i(storeWr), .tagUpdate_i(tagUpdate),
    .hit_o(hit), .hitWay_o(hitWay), .victimWay_o(victimWay),
    .victimDirty_o(victimDirty), .victimTag_o(victimTag)
  );

  dataStore u_data (
    .clk(clk),
    .reqAddr_i(reqAddr),
    .hitWay_i(hitWay), .victimWay_i(victimWay),
    .storeWr_i(storeWr), .storeData_i(storeData), .storeMask_i(storeMask),
    .lineFill_i(lineFill), .fillLine_i(lineBuffer),
    .rdWord_o(respData_o), .victimLine_o(victimLine)
  );

  refillUnit u_refill (
    .clk(clk), .rst_n(rst_n),
    .startRead_i(startRead), .startWrBack_i(startWrBack),
    .lineAddr_i(reqAddr), .victimTag_i(victimTag), .victimLine_i(victimLine),
    .rdValid_o(rdValid_o), .rdReq_o(rdReq_o),
    .rdReady_i(rdReady_i), .beatValid_i(beatValid_i), .beat_i(beat_i),
    .wrValid_o(wrValid_o), .wrReq_o(wrReq_o), .wrReady_i(wrReady_i),
    .rdAccepted_o(rdAccepted), .wrAccepted_o(wrAccepted), .fillDone_o(fillDone),
    .lineBuffer_o(lineBuffer)
  );

endmodule

`default_nettype wire

//--- rtl/refillUnit.sv
`timescale 1ns/1ps
`default_nettype none

module refillUnit (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           startRead_i,
  input  wire                           startWrBack_i,
  input  wire cachePkg::addrFields_t    lineAddr_i,
  input  wire [cachePkg::TagWidth-1:0]  victimTag_i,
  input  wire memBusPkg::line_t         victimLine_i,
  output logic                          rdValid_o,
  output memBusPkg::rdReq_t             rdReq_o,
  input  wire                           rdReady_i,
  input  wire                           beatValid_i,
  input  wire memBusPkg::rdBeat_t       beat_i,
  output logic                          wrValid_o,
  output memBusPkg::wrReq_t             wrReq_o,
  input  wire                           wrReady_i,
  output logic                          rdAccepted_o,
  output logic                          wrAccepted_o,
  output logic                          fillDone_o,
  output memBusPkg::line_t              lineBuffer_o
);

  logic [memBusPkg::BeatCntWidth-1:0] beatCnt;
  logic                               filling;
  logic                               beatTake;

  assign rdAccepted_o = rdValid_o && rdReady_i;
  assign wrAccepted_o = wrValid_o && wrReady_i;
  assign beatTake = filling && beatValid_i;
  assign fillDone_o = beatTake && beat_i.last;

  // valids hold until the memory takes the request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdValid_o <= 1'b0;
      wrValid_o <= 1'b0;
      filling <= 1'b0;
      beatCnt <= '0;
    end else begin
      if (startRead_i) begin
        rdValid_o <= 1'b1;
      end else if (rdAccepted_o) begin
        rdValid_o <= 1'b0;
      end
      if (startWrBack_i) begin
        wrValid_o <= 1'b1;
      end else if (wrAccepted_o) begin
        wrValid_o <= 1'b0;
      end
      if (rdAccepted_o) begin
        filling <= 1'b1;
      end else if (fillDone_o) begin
        filling <= 1'b0;
      end
      if (startRead_i) begin
        beatCnt <= '0;
      end else if (beatTake) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  // beats land in address order
  always_ff @(posedge clk) begin
    if (startRead_i) begin
      rdReq_o.lineAddr <= {lineAddr_i.tag, lineAddr_i.index, {cachePkg::OffsetWidth{1'b0}}};
    end
    if (startWrBack_i) begin
      wrReq_o.lineAddr <= {victimTag_i, lineAddr_i.index, {cachePkg::OffsetWidth{1'b0}}};
      wrReq_o.data <= victimLine_i;
    end
    if (beatTake) begin
      lineBuffer_o[beatCnt*memBusPkg::BeatWidth +: memBusPkg::BeatWidth] <= beat_i.data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/dataStore.sv
`timescale 1ns/1ps
`default_nettype none

module dataStore (
  input  wire                        clk,
  input  wire cachePkg::addrFields_t reqAddr_i,
  input  wire                        hitWay_i,
  input  wire                        victimWay_i,
  input  wire                        storeWr_i,
  input  wire cachePkg::word_t       storeData_i,
  input  wire cachePkg::byteMask_t   storeMask_i,
  input  wire                        lineFill_i,
  input  wire memBusPkg::line_t      fillLine_i,
  output cachePkg::word_t            rdWord_o,
  output memBusPkg::line_t           victimLine_o
);

  localparam int HalfWidth = memBusPkg::LineWidth / 2;
  localparam int HalfBytes = HalfWidth / 8;

  // way, half, set
  logic [HalfWidth-1:0] halfArr [2][2][cachePkg::NumSets];
  logic [HalfBytes-1:0] halfMask;
  logic [HalfWidth-1:0] halfData;
  memBusPkg::line_t     hitLine;

  // offset[3] picks the doubleword inside the 128-bit half
  assign halfMask = reqAddr_i.offset[3] ? {storeMask_i, {cachePkg::MaskWidth{1'b0}}}
                                        : {{cachePkg::MaskWidth{1'b0}}, storeMask_i};
  assign halfData = {2{storeData_i}};

  always_ff @(posedge clk) begin
    if (lineFill_i) begin
      halfArr[victimWay_i][0][reqAddr_i.index] <= fillLine_i[HalfWidth-1:0];
      halfArr[victimWay_i][1][reqAddr_i.index] <= fillLine_i[2*HalfWidth-1:HalfWidth];
    end else if (storeWr_i) begin
      // masked bytes only, offset[4] picks the half
      for (int b = 0; b < HalfBytes; b++) begin
        if (halfMask[b]) begin
          halfArr[hitWay_i][reqAddr_i.offset[4]][reqAddr_i.index][b*8 +: 8] <=
            halfData[b*8 +: 8];
        end
      end
    end
  end

  assign hitLine = {halfArr[hitWay_i][1][reqAddr_i.index],
                    halfArr[hitWay_i][0][reqAddr_i.index]};

  assign victimLine_o = {halfArr[victimWay_i][1][reqAddr_i.index],
                         halfArr[victimWay_i][0][reqAddr_i.index]};

  assign rdWord_o = hitLine[reqAddr_i.offset[4:3]*cachePkg::WordWidth +: cachePkg::WordWidth];

endmodule

`default_nettype wire

//--- rtl/tagStore.sv
`timescale 1ns/1ps
`default_nettype none

module tagStore #(
  parameter logic [15:0] VictimSeed = 16'hace1
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire cachePkg::addrFields_t   reqAddr_i,
  input  wire                          checkEn_i,
  input  wire                          storeWr_i,
  input  wire                          tagUpdate_i,
  output logic                         hit_o,
  output logic                         hitWay_o,
  output logic                         victimWay_o,
  output logic                         victimDirty_o,
  output logic [cachePkg::TagWidth-1:0] victimTag_o
);

  logic [cachePkg::TagWidth-1:0] tagArr [2][cachePkg::NumSets];
  logic [cachePkg::NumSets-1:0]  validArr [2];
  logic [cachePkg::NumSets-1:0]  dirtyArr [2];
  logic [1:0]                    wayValid;
  logic [1:0]                    wayHit;
  logic [15:0]                   lfsr;
  logic                          lfsrFeedback;

  // both ways compared in parallel on the latched index
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayValid[w] = validArr[w][reqAddr_i.index];
      wayHit[w] = wayValid[w] && (tagArr[w][reqAddr_i.index] == reqAddr_i.tag);
    end
  end

  assign hit_o = |wayHit;
  assign hitWay_o = wayHit[1];

  // empty way first, otherwise pseudo-random
  always_comb begin
    if (!wayValid[0]) begin
      victimWay_o = 1'b0;
    end else if (!wayValid[1]) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = lfsr[0];
    end
  end

  assign victimDirty_o = dirtyArr[victimWay_o][reqAddr_i.index];
  assign victimTag_o = tagArr[victimWay_o][reqAddr_i.index];

  // x^16 + x^14 + x^13 + x^11 + 1
  assign lfsrFeedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

  // only steps on completed lookups, so the victim holds through a miss
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= VictimSeed;
    end else if (checkEn_i) begin
      lfsr <= {lfsr[14:0], lfsrFeedback};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '{default: '0};
      dirtyArr <= '{default: '0};
    end else if (tagUpdate_i) begin
      validArr[victimWay_o][reqAddr_i.index] <= 1'b1;
      dirtyArr[victimWay_o][reqAddr_i.index] <= 1'b0;
    end else if (storeWr_i) begin
      dirtyArr[hitWay_o][reqAddr_i.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tagUpdate_i) begin
      tagArr[victimWay_o][reqAddr_i.index] <= reqAddr_i.tag;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cacheCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      reqValid_i,
  input  wire cachePkg::cacheReq_t req_i,
  output logic                     reqReady_o,
  output logic                     respValid_o,
  output cachePkg::addrFields_t    reqAddr_o,
  output cachePkg::word_t          storeData_o,
  output cachePkg::byteMask_t      storeMask_o,
  input  wire                      hit_i,
  input  wire                      victimDirty_i,
  output logic                     storeWr_o,
  output logic                     lineFill_o,
  output logic                     tagUpdate_o,
  output logic                     startRead_o,
  output logic                     startWrBack_o,
  input  wire                      rdAccepted_i,
  input  wire                      wrAccepted_i,
  input  wire                      fillDone_i
);

  cachePkg::ctrlState_e state;
  cachePkg::ctrlState_e stateNext;
  cachePkg::cacheReq_t  reqQ;
  logic                 inCompare;
  logic                 missClean;
  logic                 missDirty;

  assign inCompare = (state == cachePkg::stCompare);
  assign missClean = inCompare && !hit_i && !victimDirty_i;
  assign missDirty = inCompare && !hit_i && victimDirty_i;

  // one request in flight, accepted only while idle
  always_ff @(posedge clk) begin
    if (reqValid_i && reqReady_o) begin
      reqQ <= req_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cachePkg::stIdle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      cachePkg::stIdle: begin
        if (reqValid_i) begin
          stateNext = cachePkg::stCompare;
        end
      end
      cachePkg::stCompare: begin
        if (hit_i) begin
          stateNext = cachePkg::stIdle;
        end else if (victimDirty_i) begin
          stateNext = cachePkg::stWriteBack;
        end else begin
          stateNext = cachePkg::stMiss;
        end
      end
      cachePkg::stWriteBack: begin
        if (wrAccepted_i) begin
          stateNext = cachePkg::stMiss;
        end
      end
      cachePkg::stMiss: begin
        if (rdAccepted_i) begin
          stateNext = cachePkg::stGetData;
        end
      end
      cachePkg::stGetData: begin
        if (fillDone_i) begin
          stateNext = cachePkg::stReplace;
        end
      end
      // line goes into the victim way, then the compare is re-run
      cachePkg::stReplace: begin
        stateNext = cachePkg::stCompare;
      end
      default: begin
        stateNext = cachePkg::stIdle;
      end
    endcase
  end

  assign reqReady_o = (state == cachePkg::stIdle);
  assign respValid_o = inCompare && hit_i;
  assign storeWr_o = respValid_o && (reqQ.op == cachePkg::opStore);

  // read starts straight from compare, or after the victim is accepted
  assign startWrBack_o = missDirty;
  assign startRead_o = missClean || ((state == cachePkg::stWriteBack) && wrAccepted_i);

  assign lineFill_o = (state == cachePkg::stReplace);
  assign tagUpdate_o = (state == cachePkg::stReplace);

  assign reqAddr_o = reqQ.addr;
  assign storeData_o = reqQ.data;
  assign storeMask_o = reqQ.mask;

endmodule

`default_nettype wire

//--- rtl/memBusPkg.sv
`default_nettype none

package memBusPkg;

  // refill beats per line and beat counter width
  localparam int BeatsPerLine = 4;
  localparam int BeatCntWidth = $clog2(BeatsPerLine);
  localparam int BeatWidth = cachePkg::WordWidth;
  localparam int LineWidth = cachePkg::LineBytes * 8;

  typedef logic [LineWidth-1:0] line_t;

  // line-aligned read request
  typedef struct packed {
    logic [cachePkg::AddrWidth-1:0] lineAddr;
  } rdReq_t;

  typedef struct packed {
    logic [BeatWidth-1:0] data;
    logic                 last;
  } rdBeat_t;

  // whole-line write-back
  typedef struct packed {
    logic [cachePkg::AddrWidth-1:0] lineAddr;
    line_t                          data;
  } wrReq_t;

endpackage

`default_nettype wire

//--- rtl/cachePkg.sv
`default_nettype none

package cachePkg;

  // geometry
  localparam int AddrWidth = 32;
  localparam int WordWidth = 64;
  localparam int LineBytes = 32;
  localparam int NumSets = 64;
  localparam int TagWidth = 21;
  localparam int IndexWidth = 6;
  localparam int OffsetWidth = 5;
  localparam int MaskWidth = WordWidth / 8;

  // byte address split into tag, set index and line offset
  typedef struct packed {
    logic [TagWidth-1:0]    tag;
    logic [IndexWidth-1:0]  index;
    logic [OffsetWidth-1:0] offset;
  } addrFields_t;

  typedef logic [WordWidth-1:0] word_t;

  // one bit per byte of the aligned doubleword
  typedef logic [MaskWidth-1:0] byteMask_t;

  typedef enum logic {
    opLoad,
    opStore
  } cacheOp_e;

  typedef struct packed {
    cacheOp_e    op;
    addrFields_t addr;
    word_t       data;
    byteMask_t   mask;
  } cacheReq_t;

  typedef enum logic [2:0] {
    stIdle,
    stCompare,
    stWriteBack,
    stMiss,
    stGetData,
    stReplace
  } ctrlState_e;

endpackage

`default_nettype wire
